//--- logic/pixel_readout_pkg.sv
/* Word format, source tags and register map shared by the readout data path.
   Modules import it inside their bodies and use scoped names in port lists. */
package pixel_readout_pkg;

    // tagged 32-bit readout word
    typedef struct packed {
        logic [3:0]  tag;
        logic [27:0] payload;
    } data_word_t;

    // source identifiers in the top nibble
    localparam logic [3:0] TAG_SR  = 4'd1;
    localparam logic [3:0] TAG_TDC = 4'd4;

    // serial bits per pixel shift-register frame
    localparam int SR_BITS = 24;

    // register offsets from the base address
    localparam logic [15:0] REG_CTRL   = 16'd0;
    localparam logic [15:0] REG_LOST   = 16'd1;
    localparam logic [15:0] REG_STATUS = 16'd2;

    // source enables, bit 0 is the serial receiver
    typedef struct packed {
        logic tdc_en;
        logic sr_en;
    } ctrl_t;

endpackage

//--- logic/sr_rx.sv
/* Pixel shift-register receiver. Samples one bit per clock while the serial
   enable is high and emits a tagged word after every full frame. */
`timescale 1ns/1ps

module sr_rx (
    input  logic                             i_bus_clk,
    input  logic                             i_rst,
    input  logic                             i_en,
    input  logic                             i_sr_en,
    input  logic                             i_sdi,
    output pixel_readout_pkg::data_word_t    o_word,
    output logic                             o_valid
);
    import pixel_readout_pkg::*;

    localparam int CNT_W = $clog2(SR_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SR_BITS - 1);

    logic [CNT_W-1:0]   bit_cnt;
    logic [3:0]         frame_cnt;
    logic [SR_BITS-1:0] shreg;
    logic               sampling;

    assign sampling = i_en && i_sr_en;

    always_ff @(posedge i_bus_clk) begin
        if (i_rst) begin
            bit_cnt   <= '0;
            frame_cnt <= '0;
            o_valid   <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (!sampling) begin
                // partial frame is dropped
                bit_cnt <= '0;
            end else if (bit_cnt == LAST_BIT) begin
                bit_cnt   <= '0;
                frame_cnt <= frame_cnt + 1'b1;
                o_valid   <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // first bit ends up in the MSB
    always_ff @(posedge i_bus_clk) begin
        if (sampling) begin
            shreg <= {shreg[SR_BITS-2:0], i_sdi};
            if (bit_cnt == LAST_BIT) begin
                o_word.tag     <= TAG_SR;
                o_word.payload <= {frame_cnt, shreg[SR_BITS-2:0], i_sdi};
            end
        end
    end

endmodule

//--- logic/hit_tdc.sv
/* Hit-OR pulse-width TDC. Counts bus clocks while the hit input is high and
   emits a tagged word with event number and length on the falling edge. */
`timescale 1ns/1ps

module hit_tdc (
    input  logic                             i_bus_clk,
    input  logic                             i_rst,
    input  logic                             i_en,
    input  logic                             i_hit_or,
    output pixel_readout_pkg::data_word_t    o_word,
    output logic                             o_valid
);
    import pixel_readout_pkg::*;

    logic        hit_q;
    logic        armed;
    logic        rise;
    logic        fall;
    logic [15:0] len;
    logic [11:0] evt_cnt;

    assign rise = i_hit_or && !hit_q;
    assign fall = !i_hit_or && hit_q;

    always_ff @(posedge i_bus_clk) begin
        if (i_rst) begin
            hit_q   <= 1'b0;
            armed   <= 1'b0;
            evt_cnt <= '0;
            o_valid <= 1'b0;
        end else begin
            hit_q   <= i_hit_or;
            o_valid <= 1'b0;
            // enable is sampled at the start of each pulse
            if (rise) begin
                armed <= i_en;
            end else if (fall) begin
                armed <= 1'b0;
                if (armed) begin
                    o_valid <= 1'b1;
                    evt_cnt <= evt_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (rise) begin
            len <= 16'd1;
        end else if (i_hit_or && len != 16'hFFFF) begin
            len <= len + 1'b1;
        end
        if (fall) begin
            o_word.tag     <= TAG_TDC;
            o_word.payload <= {evt_cnt, len};
        end
    end

endmodule

//--- logic/word_fifo.sv
/* Synchronous first-word-fall-through FIFO of readout words. The head word is
   shown on o_data whenever o_empty is low; a push into a full FIFO is dropped. */
`timescale 1ns/1ps

module word_fifo #(
    parameter  int DEPTH = 4,
    localparam int CNT_W = $clog2(DEPTH + 1)
) (
    input  logic                             i_bus_clk,
    input  logic                             i_rst,
    input  logic                             i_push,
    input  pixel_readout_pkg::data_word_t    i_data,
    input  logic                             i_pop,
    output pixel_readout_pkg::data_word_t    o_data,
    output logic                             o_empty,
    output logic                             o_full,
    output logic [CNT_W-1:0]                 o_count,
    output logic                             o_drop
);
    import pixel_readout_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    data_word_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == CNT_W'(DEPTH));
    assign wr_en   = i_push && !o_full;
    assign rd_en   = i_pop && !o_empty;
    assign o_drop  = i_push && o_full;
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge i_bus_clk) begin
        if (i_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            if (wr_en && !rd_en) begin
                o_count <= o_count + 1'b1;
            end else if (rd_en && !wr_en) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (wr_en) mem[wr_ptr] <= i_data;
    end

    // readers must only pop a word they can see
    a_no_pop_empty: assert property (@(posedge i_bus_clk) disable iff (i_rst)
        i_pop |-> !o_empty)
        else $error("pop from empty word FIFO");

endmodule

//--- logic/rr_arbiter.sv
/* Round-robin merge of the source FIFO heads into the output FIFO.
   At most one word moves per cycle and only while the output is not full. */
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int N_SRC = 2
) (
    input  logic                                         i_bus_clk,
    input  logic                                         i_rst,
    input  logic [N_SRC-1:0]                             i_empty,
    input  pixel_readout_pkg::data_word_t [N_SRC-1:0]    i_data,
    output logic [N_SRC-1:0]                             o_pop,
    input  logic                                         i_out_full,
    output logic                                         o_push,
    output pixel_readout_pkg::data_word_t                o_word
);
    import pixel_readout_pkg::*;

    localparam int IDX_W = (N_SRC > 1) ? $clog2(N_SRC) : 1;

    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_vld;

    // search starts one past the last winner
    always_comb begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int off = 1; off <= N_SRC; off++) begin
            idx = (int'(last_q) + off) % N_SRC;
            if (!grant_vld && !i_empty[idx]) begin
                grant_vld = 1'b1;
                grant_idx = IDX_W'(idx);
            end
        end
    end

    assign o_push = grant_vld && !i_out_full;
    assign o_word = i_data[grant_idx];

    always_comb begin
        o_pop = '0;
        if (o_push) o_pop[grant_idx] = 1'b1;
    end

    // source 0 has priority after reset
    always_ff @(posedge i_bus_clk) begin
        if (i_rst) begin
            last_q <= IDX_W'(N_SRC - 1);
        end else if (o_push) begin
            last_q <= grant_idx;
        end
    end

    a_pop_onehot: assert property (@(posedge i_bus_clk) disable iff (i_rst)
        $onehot0(o_pop))
        else $error("more than one source popped in a cycle");

endmodule

//--- logic/host_out.sv
/* Output FIFO with a byte-serial host read port. o_fd shows the current byte
   of the head word, LSB first; each i_fread advances, the fourth pops the word. */
`timescale 1ns/1ps

module host_out #(
    parameter  int OUT_DEPTH = 8,
    localparam int CNT_W     = $clog2(OUT_DEPTH + 1)
) (
    input  logic                             i_bus_clk,
    input  logic                             i_rst,
    input  logic                             i_push,
    input  pixel_readout_pkg::data_word_t    i_word,
    input  logic                             i_fread,
    output logic [7:0]                       o_fd,
    output logic                             o_empty,
    output logic                             o_full,
    output logic [CNT_W-1:0]                 o_count
);
    import pixel_readout_pkg::*;

    data_word_t  head;
    logic [31:0] head_bits;
    logic [1:0]  byte_ptr;
    logic        rd_byte;
    logic        pop;
    logic        fifo_drop;

    assign rd_byte = i_fread && !o_empty;
    assign pop     = rd_byte && (byte_ptr == 2'd3);

    word_fifo #(
        .DEPTH(OUT_DEPTH)
    ) out_fifo_i (
        .i_bus_clk(i_bus_clk),
        .i_rst    (i_rst),
        .i_push   (i_push),
        .i_data   (i_word),
        .i_pop    (pop),
        .o_data   (head),
        .o_empty  (o_empty),
        .o_full   (o_full),
        .o_count  (o_count),
        .o_drop   (fifo_drop)
    );

    assign head_bits = head;
    assign o_fd      = head_bits[{byte_ptr, 3'b000} +: 8];

    always_ff @(posedge i_bus_clk) begin
        if (i_rst) begin
            byte_ptr <= 2'd0;
        end else if (rd_byte) begin
            byte_ptr <= byte_ptr + 1'b1;
        end
    end

    // the arbiter holds off while full, so nothing is lost here
    a_no_out_drop: assert property (@(posedge i_bus_clk) disable iff (i_rst)
        !fifo_drop)
        else $error("word pushed into full output FIFO");

endmodule

//--- logic/ctrl_regs.sv
/* Control and status registers on the 16-bit address bus: source enables,
   lost-word counter and output FIFO fill level. Reads return one cycle later. */
`timescale 1ns/1ps

module ctrl_regs #(
    parameter logic [15:0] BASEADDR = 16'h0000,
    parameter int          CNT_W    = 4
) (
    input  logic                        i_bus_clk,
    input  logic                        i_rst,
    input  logic [15:0]                 i_bus_add,
    input  logic [7:0]                  i_bus_wdata,
    input  logic                        i_bus_wr,
    input  logic                        i_bus_rd,
    output logic [7:0]                  o_bus_rdata,
    output pixel_readout_pkg::ctrl_t    o_ctrl,
    input  logic [1:0]                  i_drop,
    input  logic [CNT_W-1:0]            i_out_count
);
    import pixel_readout_pkg::*;

    localparam logic [15:0] ADDR_CTRL   = BASEADDR + REG_CTRL;
    localparam logic [15:0] ADDR_LOST   = BASEADDR + REG_LOST;
    localparam logic [15:0] ADDR_STATUS = BASEADDR + REG_STATUS;

    logic [7:0] lost_q;
    logic [8:0] lost_sum;
    logic [7:0] rd_mux;

    // both sources can drop in the same cycle
    assign lost_sum = {1'b0, lost_q} + 9'(i_drop[0]) + 9'(i_drop[1]);

    always_ff @(posedge i_bus_clk) begin
        if (i_rst) begin
            o_ctrl <= '0;
            lost_q <= '0;
        end else begin
            if (i_bus_wr && i_bus_add == ADDR_CTRL) o_ctrl <= ctrl_t'(i_bus_wdata[1:0]);
            if (i_bus_wr && i_bus_add == ADDR_LOST) begin
                lost_q <= '0;
            end else begin
                lost_q <= lost_sum[8] ? 8'hFF : lost_sum[7:0];
            end
        end
    end

    always_comb begin
        case (i_bus_add)
            ADDR_CTRL:   rd_mux = {6'd0, o_ctrl};
            ADDR_LOST:   rd_mux = lost_q;
            ADDR_STATUS: rd_mux = 8'(i_out_count);
            default:     rd_mux = 8'd0;
        endcase
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_rst) begin
            o_bus_rdata <= 8'd0;
        end else if (i_bus_rd) begin
            o_bus_rdata <= rd_mux;
        end
    end

endmodule

//--- logic/pixel_readout_top.sv
/* Readout data path top level: serial receiver and TDC feed source FIFOs, the
   arbiter merges them into the host byte port, registers sit on the bus. */
`timescale 1ns/1ps

module pixel_readout_top #(
    parameter int          SRC_DEPTH    = 4,
    parameter int          OUT_DEPTH    = 8,
    parameter logic [15:0] REG_BASEADDR = 16'h0000
) (
    input  logic        i_bus_clk,
    input  logic        i_rst,
    input  logic [15:0] i_bus_add,
    input  logic [7:0]  i_bus_wdata,
    input  logic        i_bus_wr,
    input  logic        i_bus_rd,
    output logic [7:0]  o_bus_rdata,
    input  logic        i_sr_en,
    input  logic        i_sdi,
    input  logic        i_hit_or,
    input  logic        i_fread,
    output logic [7:0]  o_fd,
    output logic        o_empty
);
    import pixel_readout_pkg::*;

    localparam int OUT_CNT_W = $clog2(OUT_DEPTH + 1);

    ctrl_t                ctrl;
    data_word_t           sr_word;
    data_word_t           tdc_word;
    logic                 sr_valid;
    logic                 tdc_valid;
    // index 0 serial receiver, index 1 TDC
    data_word_t [1:0]     src_data;
    logic [1:0]           src_empty;
    logic [1:0]           src_pop;
    logic [1:0]           src_drop;
    logic                 arb_push;
    data_word_t           arb_word;
    logic                 out_full;
    logic [OUT_CNT_W-1:0] out_count;

    sr_rx sr_rx_i (
        .i_bus_clk(i_bus_clk),
        .i_rst    (i_rst),
        .i_en     (ctrl.sr_en),
        .i_sr_en  (i_sr_en),
        .i_sdi    (i_sdi),
        .o_word   (sr_word),
        .o_valid  (sr_valid)
    );

    hit_tdc hit_tdc_i (
        .i_bus_clk(i_bus_clk),
        .i_rst    (i_rst),
        .i_en     (ctrl.tdc_en),
        .i_hit_or (i_hit_or),
        .o_word   (tdc_word),
        .o_valid  (tdc_valid)
    );

    word_fifo #(
        .DEPTH(SRC_DEPTH)
    ) sr_fifo_i (
        .i_bus_clk(i_bus_clk),
        .i_rst    (i_rst),
        .i_push   (sr_valid),
        .i_data   (sr_word),
        .i_pop    (src_pop[0]),
        .o_data   (src_data[0]),
        .o_empty  (src_empty[0]),
        .o_full   (),
        .o_count  (),
        .o_drop   (src_drop[0])
    );

    word_fifo #(
        .DEPTH(SRC_DEPTH)
    ) tdc_fifo_i (
        .i_bus_clk(i_bus_clk),
        .i_rst    (i_rst),
        .i_push   (tdc_valid),
        .i_data   (tdc_word),
        .i_pop    (src_pop[1]),
        .o_data   (src_data[1]),
        .o_empty  (src_empty[1]),
        .o_full   (),
        .o_count  (),
        .o_drop   (src_drop[1])
    );

    rr_arbiter #(
        .N_SRC(2)
    ) arbiter_i (
        .i_bus_clk (i_bus_clk),
        .i_rst     (i_rst),
        .i_empty   (src_empty),
        .i_data    (src_data),
        .o_pop     (src_pop),
        .i_out_full(out_full),
        .o_push    (arb_push),
        .o_word    (arb_word)
    );

    host_out #(
        .OUT_DEPTH(OUT_DEPTH)
    ) host_out_i (
        .i_bus_clk(i_bus_clk),
        .i_rst    (i_rst),
        .i_push   (arb_push),
        .i_word   (arb_word),
        .i_fread  (i_fread),
        .o_fd     (o_fd),
        .o_empty  (o_empty),
        .o_full   (out_full),
        .o_count  (out_count)
    );

    ctrl_regs #(
        .BASEADDR(REG_BASEADDR),
        .CNT_W   (OUT_CNT_W)
    ) ctrl_regs_i (
        .i_bus_clk  (i_bus_clk),
        .i_rst      (i_rst),
        .i_bus_add  (i_bus_add),
        .i_bus_wdata(i_bus_wdata),
        .i_bus_wr   (i_bus_wr),
        .i_bus_rd   (i_bus_rd),
        .o_bus_rdata(o_bus_rdata),
        .o_ctrl     (ctrl),
        .i_drop     (src_drop),
        .i_out_count(out_count)
    );

endmodule

//--- sim/tb_pixel_readout.sv
/* Self-checking testbench for the pixel readout data path. Drives serial frames,
   hit pulses and bus accesses, and checks host bytes against a reference model. */
`timescale 1ns/1ps

module tb_pixel_readout;
    import pixel_readout_pkg::*;

    localparam int          SRC_DEPTH = 4;
    localparam int          OUT_DEPTH = 8;
    localparam logic [15:0] BASE      = 16'h0000;
    localparam logic [15:0] ADDR_CTRL   = BASE + REG_CTRL;
    localparam logic [15:0] ADDR_LOST   = BASE + REG_LOST;
    localparam logic [15:0] ADDR_STATUS = BASE + REG_STATUS;
    localparam int          N_BURST   = 20;
    // all tests together need about 1500 cycles, the 300 cycle pulse being the longest
    localparam int          MAX_CYCLES = 20000;

    logic        bus_clk;
    logic        rst;
    logic [15:0] bus_add;
    logic [7:0]  bus_wdata;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_rdata;
    logic        sr_en;
    logic        sdi;
    logic        hit_or;
    logic        fread;
    logic [7:0]  fd;
    logic        empty;

    data_word_t  exp_sr[$];
    data_word_t  exp_tdc[$];
    logic [31:0] lcg_state = 32'd16;
    logic [31:0] rd_word;
    int          byte_idx = 0;
    bit          read_en;
    int          sr_count = 0;
    int          tdc_count = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_ok = 0;
    int          cycle_cnt = 0;
    int          start_err;

    pixel_readout_top #(
        .SRC_DEPTH   (SRC_DEPTH),
        .OUT_DEPTH   (OUT_DEPTH),
        .REG_BASEADDR(BASE)
    ) dut_i (
        .i_bus_clk  (bus_clk),
        .i_rst      (rst),
        .i_bus_add  (bus_add),
        .i_bus_wdata(bus_wdata),
        .i_bus_wr   (bus_wr),
        .i_bus_rd   (bus_rd),
        .o_bus_rdata(bus_rdata),
        .i_sr_en    (sr_en),
        .i_sdi      (sdi),
        .i_hit_or   (hit_or),
        .i_fread    (fread),
        .o_fd       (fd),
        .o_empty    (empty)
    );

    always #10 bus_clk = ~bus_clk;

    always @(posedge bus_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, readout never drained", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic rand_bit();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[16];
    endfunction

    // word layout: tag, then counter and data as each source packs them
    function automatic data_word_t expected_word(input logic [3:0] tag, input int count,
                                                 input int value);
        data_word_t  w;
        logic [15:0] len;
        len = (value > 65535) ? 16'hFFFF : value[15:0];
        w.tag = tag;
        if (tag == TAG_SR) begin
            w.payload = {count[3:0], value[23:0]};
        end else begin
            w.payload = {count[11:0], len};
        end
        return w;
    endfunction

    task automatic check_word(input logic [31:0] got);
        data_word_t exp;
        if (got[31:28] == TAG_SR && exp_sr.size() > 0) begin
            exp = exp_sr.pop_front();
        end else if (got[31:28] == TAG_TDC && exp_tdc.size() > 0) begin
            exp = exp_tdc.pop_front();
        end else begin
            $display("unexpected word %h read at %0t, no word of that tag was due", got, $time);
            errors++;
            return;
        end
        if (got != exp) begin
            $display("error at %0t: o_fd word expected %h got %h", $time, exp, got);
            errors++;
        end
    endtask

    task automatic check_empty(input logic exp);
        if (empty !== exp) begin
            $display("error at %0t: o_empty expected %b got %b", $time, exp, empty);
            errors++;
        end
    endtask

    // host reader, one byte per cycle while data is shown
    always @(posedge bus_clk) begin
        #2;
        if (read_en && !empty) begin
            rd_word[byte_idx*8 +: 8] = fd;
            fread = 1'b1;
            if (byte_idx == 3) begin
                byte_idx = 0;
                check_word(rd_word);
            end else begin
                byte_idx++;
            end
        end else begin
            fread = 1'b0;
        end
    end

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge bus_clk);
        #2;
        bus_add   = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(posedge bus_clk);
        #2;
        bus_wr = 1'b0;
    endtask

    task automatic check_reg(input logic [15:0] addr, input logic [7:0] exp, input string name);
        logic [7:0] got;
        @(posedge bus_clk);
        #2;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge bus_clk);
        #2;
        bus_rd = 1'b0;
        got    = bus_rdata;
        if (got != exp) begin
            $display("error at %0t: o_bus_rdata (%s) expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // first bit lands in bit 23
    task automatic send_frame();
        logic [23:0] bits;
        for (int i = 23; i >= 0; i--) begin
            bits[i] = rand_bit();
        end
        for (int i = 23; i >= 0; i--) begin
            @(posedge bus_clk);
            #2;
            sr_en = 1'b1;
            sdi   = bits[i];
        end
        exp_sr.push_back(expected_word(TAG_SR, sr_count, int'(bits)));
        sr_count++;
    endtask

    task automatic stop_serial();
        @(posedge bus_clk);
        #2;
        sr_en = 1'b0;
        sdi   = 1'b0;
    endtask

    task automatic send_pulse(input int len, input bit enabled, input bit kept);
        @(posedge bus_clk);
        #2;
        hit_or = 1'b1;
        repeat (len) @(posedge bus_clk);
        #2;
        hit_or = 1'b0;
        if (enabled) begin
            if (kept) exp_tdc.push_back(expected_word(TAG_TDC, tdc_count, len));
            tdc_count++;
        end
        repeat (3) @(posedge bus_clk);
    endtask

    task automatic wait_drain();
        @(negedge bus_clk);
        while (exp_sr.size() != 0 || exp_tdc.size() != 0 || !empty || byte_idx != 0) begin
            @(negedge bus_clk);
        end
        // a stray word would show up here
        repeat (8) @(negedge bus_clk);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        bus_clk   = 1'b0;
        rst       = 1'b1;
        bus_add   = '0;
        bus_wdata = '0;
        bus_wr    = 1'b0;
        bus_rd    = 1'b0;
        sr_en     = 1'b0;
        sdi       = 1'b0;
        hit_or    = 1'b0;
        fread     = 1'b0;
        read_en   = 1'b1;
        repeat (8) @(posedge bus_clk);
        #2;
        rst = 1'b0;

        start_err = errors;
        check_empty(1'b1);
        check_reg(ADDR_CTRL, 8'd0, "REG_CTRL");
        check_reg(ADDR_LOST, 8'd0, "REG_LOST");
        bus_write(ADDR_CTRL, 8'd3);
        check_reg(ADDR_CTRL, 8'd3, "REG_CTRL");
        end_test("registers", start_err);

        start_err = errors;
        repeat (3) send_frame();
        stop_serial();
        // partial frame, dropped when the enable falls
        repeat (10) begin
            @(posedge bus_clk);
            #2;
            sr_en = 1'b1;
            sdi   = rand_bit();
        end
        stop_serial();
        wait_drain();
        end_test("shift register", start_err);

        start_err = errors;
        send_pulse(1, 1'b1, 1'b1);
        send_pulse(5, 1'b1, 1'b1);
        send_pulse(300, 1'b1, 1'b1);
        bus_write(ADDR_CTRL, 8'd1);
        send_pulse(4, 1'b0, 1'b0);
        send_pulse(9, 1'b0, 1'b0);
        bus_write(ADDR_CTRL, 8'd3);
        wait_drain();
        end_test("tdc", start_err);

        start_err = errors;
        fork
            begin
                repeat (4) send_frame();
                stop_serial();
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    send_pulse(4 + i, 1'b1, 1'b1);
                end
            end
        join
        wait_drain();
        check_reg(ADDR_LOST, 8'd0, "REG_LOST");
        end_test("merge", start_err);

        start_err = errors;
        bus_write(ADDR_LOST, 8'd0);
        @(negedge bus_clk);
        read_en = 1'b0;
        for (int i = 0; i < N_BURST; i++) begin
            send_pulse(i + 1, 1'b1, i < OUT_DEPTH + SRC_DEPTH);
        end
        repeat (4) @(posedge bus_clk);
        check_reg(ADDR_STATUS, 8'(OUT_DEPTH), "REG_STATUS");
        check_reg(ADDR_LOST, 8'(N_BURST - OUT_DEPTH - SRC_DEPTH), "REG_LOST");
        check_empty(1'b0);
        @(negedge bus_clk);
        read_en = 1'b1;
        wait_drain();
        check_reg(ADDR_STATUS, 8'd0, "REG_STATUS");
        end_test("overflow", start_err);

        $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_ok, errors);
        if (errors == 0 && tests_ok == tests_run) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- pixel_readout_top.f
logic/pixel_readout_pkg.sv
logic/sr_rx.sv
logic/hit_tdc.sv
logic/word_fifo.sv
logic/rr_arbiter.sv
logic/host_out.sv
logic/ctrl_regs.sv
logic/pixel_readout_top.sv
sim/tb_pixel_readout.sv

//--- Bender.yml
package:
  name: pixel_readout

sources:
  - files:
      - logic/pixel_readout_pkg.sv
      - logic/sr_rx.sv
      - logic/hit_tdc.sv
      - logic/word_fifo.sv
      - logic/rr_arbiter.sv
      - logic/host_out.sv
      - logic/ctrl_regs.sv
      - logic/pixel_readout_top.sv
  - target: test
    files:
      - sim/tb_pixel_readout.sv
